/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_uart_core \
  -Mdir obj_dir -o tb_uart_core

out=$(./obj_dir/tb_uart_core)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* sim.f */
uart_cfg_pkg.sv
uart_reg_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_rx_timer.sv
uart_core.sv
tb_uart_core.sv

/* tb_uart_core.sv */
`timescale 1ns/1ps

module tb_uart_core;

  localparam int BAUD_DIV   = 8;
  localparam int WAIT_LIMIT = 2000;  // clocks per wait loop

  logic        clk_i;
  logic        rst_ni;
  logic        ren_i;
  logic        we_i;
  logic [7:0]  addr_i;
  logic [31:0] wdata_i;
  logic [31:0] rdata_o;
  logic        tx_o;
  logic        rx_i;
  logic        intr_tx_o;
  logic        intr_rx_o;
  logic        loop_en;  // serial loopback switch

  logic [7:0]  tx_exp_q[$];  // bytes still owed on tx_o
  int          err_count     = 0;
  int          frames_done   = 0;
  int          intr_tx_count = 0;
  int          tests_run     = 0;
  int          tests_failed  = 0;

  assign rx_i = loop_en ? tx_o : 1'b1;

  uart_core uart_core_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .ren_i     ( ren_i     ),
    .we_i      ( we_i      ),
    .addr_i    ( addr_i    ),
    .wdata_i   ( wdata_i   ),
    .rdata_o   ( rdata_o   ),
    .tx_o      ( tx_o      ),
    .rx_i      ( rx_i      ),
    .intr_tx_o ( intr_tx_o ),
    .intr_rx_o ( intr_rx_o )
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // 8N1 frame with bit 0 sent first
  function automatic logic [9:0] expected_frame(input logic [7:0] data);
    return {1'b1, data, 1'b0};
  endfunction

  // samples tx_o at each bit center against the reference frame
  initial begin : frame_checker
    logic [9:0] frame;
    int         k;
    forever begin
      @(negedge clk_i);
      if (rst_ni && !tx_o) begin  // half a clock into the start bit
        if (tx_exp_q.size() == 0) begin
          $display("frame on tx_o at %0t with no byte written", $time);
          err_count++;
          repeat (10 * BAUD_DIV) @(negedge clk_i);
        end else begin
          frame = expected_frame(tx_exp_q.pop_front());
          repeat (BAUD_DIV / 2 - 1) @(negedge clk_i);
          for (k = 0; k < 10; k++) begin
            if (tx_o !== frame[k]) begin
              $display("error at %0t: tx_o bit %0d expected %b got %b",
                       $time, k, frame[k], tx_o);
              err_count++;
            end
            if (k < 9) begin
              repeat (BAUD_DIV) @(negedge clk_i);
            end
          end
          frames_done++;
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (intr_tx_o) begin
      intr_tx_count++;
    end
  end

  task automatic bus_write(input uart_reg_pkg::reg_addr_e addr, input logic [31:0] data);
    @(negedge clk_i);
    addr_i  = addr;
    wdata_i = data;
    we_i    = 1'b1;
    @(negedge clk_i);
    we_i    = 1'b0;
  endtask

  task automatic bus_read(input uart_reg_pkg::reg_addr_e addr, output logic [31:0] data);
    @(negedge clk_i);
    addr_i = addr;
    @(negedge clk_i);
    data  = rdata_o;
    ren_i = 1'b1;  // RX_DATA pops at the next edge
    @(negedge clk_i);
    ren_i = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] data);
    tx_exp_q.push_back(data);
    bus_write(uart_reg_pkg::ADDR_TX_DATA, {24'h0, data});
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      err_count++;
    end
  endtask

  task automatic wait_tx_intr(input int target);
    int cycles;
    cycles = 0;
    while (intr_tx_count < target && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (intr_tx_count < target) begin
      $display("timeout at %0t: transmit interrupt never came", $time);
      err_count++;
    end
  endtask

  task automatic wait_rx_intr(input int limit);
    int cycles;
    cycles = 0;
    while (!intr_rx_o && cycles < limit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!intr_rx_o) begin
      $display("timeout at %0t: receive timeout interrupt did not rise", $time);
      err_count++;
    end
  endtask

  task automatic wait_rx_count(input int target);
    logic [31:0] cnt;
    int          tries;
    tries = 0;
    bus_read(uart_reg_pkg::ADDR_RX_COUNT, cnt);
    while (cnt != 32'(target) && tries < WAIT_LIMIT / 3) begin
      bus_read(uart_reg_pkg::ADDR_RX_COUNT, cnt);
      tries++;
    end
    if (cnt != 32'(target)) begin
      $display("timeout at %0t: receive FIFO stuck at %0d bytes, wanted %0d",
               $time, cnt, target);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               err_count - errs_before);
    end
  endtask

  task automatic check_frames(input int got, input int exp);
    if (got != exp) begin
      $display("frame checker saw %0d frames where %0d were sent", got, exp);
      err_count++;
    end
  endtask

  initial begin : main_seq
    logic [31:0] rd;
    logic [7:0]  sent_q[$];
    logic [7:0]  b;
    int          errs;
    int          base;
    int          i;

    void'($urandom(32'h6938));
    rst_ni  = 1'b0;
    ren_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = 8'h0;
    wdata_i = 32'h0;
    loop_en = 1'b1;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    errs = err_count;
    check_word("tx_o", {31'b0, tx_o}, 32'd1);
    check_word("intr_tx_o", {31'b0, intr_tx_o}, 32'd0);
    check_word("intr_rx_o", {31'b0, intr_rx_o}, 32'd0);
    bus_read(uart_reg_pkg::ADDR_RX_STATUS, rd);
    check_word("rdata_o (RX_STATUS)", rd, 32'd0);
    bus_read(uart_reg_pkg::ADDR_RX_COUNT, rd);
    check_word("rdata_o (RX_COUNT)", rd, 32'd0);
    report_test("reset state", errs);

    errs = err_count;
    base = frames_done;
    intr_tx_count = 0;
    bus_write(uart_reg_pkg::ADDR_CTRL, 32'(BAUD_DIV));
    bus_write(uart_reg_pkg::ADDR_TX_EN, 32'd1);
    send_byte(8'($urandom));
    wait_tx_intr(1);
    check_frames(frames_done - base, 1);
    report_test("frame shape", errs);

    errs = err_count;
    base = frames_done;
    intr_tx_count = 0;
    bus_write(uart_reg_pkg::ADDR_RX_EN, 32'd1);
    for (i = 0; i < 6; i++) begin
      b = 8'($urandom);
      sent_q.push_back(b);
      send_byte(b);
    end
    wait_tx_intr(1);
    check_frames(frames_done - base, 6);  // pulse only after the sixth frame
    wait_rx_count(6);
    for (i = 0; i < 6; i++) begin
      bus_read(uart_reg_pkg::ADDR_RX_COUNT, rd);
      check_word("rdata_o (RX_COUNT)", rd, 32'(6 - i));
      bus_read(uart_reg_pkg::ADDR_RX_DATA, rd);
      check_word("rdata_o (RX_DATA)", rd, {24'h0, sent_q.pop_front()});
    end
    bus_read(uart_reg_pkg::ADDR_RX_COUNT, rd);
    check_word("rdata_o (RX_COUNT)", rd, 32'd0);
    check_word("intr_tx_o pulse count", 32'(intr_tx_count), 32'd1);
    report_test("loopback", errs);

    errs = err_count;
    intr_tx_count = 0;
    bus_write(uart_reg_pkg::ADDR_RX_EN, 32'd0);
    send_byte(8'($urandom));
    send_byte(8'($urandom));
    wait_tx_intr(1);
    bus_read(uart_reg_pkg::ADDR_RX_COUNT, rd);
    check_word("rdata_o (RX_COUNT)", rd, 32'd0);
    loop_en = 1'b0;  // line held idle, receiver on
    intr_tx_count = 0;
    bus_write(uart_reg_pkg::ADDR_RX_EN, 32'd1);
    send_byte(8'($urandom));
    wait_tx_intr(1);
    bus_read(uart_reg_pkg::ADDR_RX_COUNT, rd);
    check_word("rdata_o (RX_COUNT)", rd, 32'd0);
    loop_en = 1'b1;
    report_test("receiver disabled", errs);

    errs = err_count;
    intr_tx_count = 0;
    bus_write(uart_reg_pkg::ADDR_RX_TIMEOUT, 32'd200);
    bus_write(uart_reg_pkg::ADDR_RX_EN, 32'd1);
    b = 8'($urandom);
    send_byte(b);
    wait_tx_intr(1);
    check_word("intr_rx_o", {31'b0, intr_rx_o}, 32'd0);  // too early to time out
    wait_rx_intr(300);
    bus_read(uart_reg_pkg::ADDR_RX_STATUS, rd);
    check_word("rdata_o (RX_STATUS)", rd, 32'd1);
    bus_write(uart_reg_pkg::ADDR_RX_STATUS_CLR, 32'd1);
    check_word("intr_rx_o", {31'b0, intr_rx_o}, 32'd0);
    bus_read(uart_reg_pkg::ADDR_RX_STATUS, rd);
    check_word("rdata_o (RX_STATUS)", rd, 32'd0);
    bus_read(uart_reg_pkg::ADDR_RX_DATA, rd);
    check_word("rdata_o (RX_DATA)", rd, {24'h0, b});
    report_test("receive timeout", errs);

    errs = err_count;
    intr_tx_count = 0;
    for (i = 0; i < 3; i++) begin
      send_byte(8'($urandom));
    end
    wait_tx_intr(1);
    wait_rx_count(3);
    bus_write(uart_reg_pkg::ADDR_RX_FLUSH, 32'd1);
    bus_read(uart_reg_pkg::ADDR_RX_COUNT, rd);
    check_word("rdata_o (RX_COUNT)", rd, 32'd0);
    report_test("receive flush", errs);

    if (tx_exp_q.size() != 0) begin
      $display("%0d written bytes never appeared on tx_o", tx_exp_q.size());
      err_count++;
    end
    $display("%0d tests, %0d failed, %0d errors, %0d frames checked",
             tests_run, tests_failed, err_count, frames_done);
    if (err_count == 0 && tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* uart_cfg_pkg.sv */
package uart_cfg_pkg;

  localparam int DATA_W     = 8;   // serial byte
  localparam int FIFO_DEPTH = 128;
  localparam int CNT_W      = 8;   // holds 0..FIFO_DEPTH

  typedef logic [15:0] baud_div_t; // clocks per bit

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  // the receiver confirms the start bit at half a bit
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

/* uart_core.sv */
`timescale 1ns/1ps

module uart_core (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        ren_i,
  input  logic        we_i,
  input  logic [7:0]  addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        tx_o,
  input  logic        rx_i,
  output logic        intr_tx_o,
  output logic        intr_rx_o
);

  uart_reg_pkg::uart_ctrl_t        ctrl_q;
  uart_reg_pkg::reg_addr_e         addr;
  logic                            wr_en;
  logic                            status_q;
  logic                            status_clr;
  logic                            intr_tx_q;

  logic                            tx_push;
  logic                            tx_flush;
  logic                            tx_empty;
  logic                            tx_start;
  logic                            tx_busy;
  logic                            tx_done;
  logic [uart_cfg_pkg::DATA_W-1:0] tx_head;

  logic                            rx_pop;
  logic                            rx_flush;
  logic                            rx_gated;
  logic                            rx_valid;
  logic                            rx_start;
  logic                            rx_timeout;
  logic [uart_cfg_pkg::DATA_W-1:0] rx_byte;
  logic [uart_cfg_pkg::DATA_W-1:0] rx_head;
  logic [uart_cfg_pkg::CNT_W-1:0]  rx_count;

  assign addr  = uart_reg_pkg::reg_addr_e'(addr_i);
  assign wr_en = we_i & ~ren_i;

  assign tx_push    = wr_en && (addr == uart_reg_pkg::ADDR_TX_DATA);
  assign tx_flush   = wr_en && (addr == uart_reg_pkg::ADDR_TX_FLUSH) && wdata_i[0];
  assign rx_flush   = wr_en && (addr == uart_reg_pkg::ADDR_RX_FLUSH) && wdata_i[0];
  assign status_clr = wr_en && (addr == uart_reg_pkg::ADDR_RX_STATUS_CLR);
  assign rx_pop     = ren_i && (addr == uart_reg_pkg::ADDR_RX_DATA);

  // next frame as soon as the engine is free
  assign tx_start = ctrl_q.tx_en & ~tx_empty & ~tx_busy;
  assign rx_gated = ctrl_q.rx_en ? rx_i : 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (wr_en) begin
      case (addr)
        uart_reg_pkg::ADDR_CTRL:       ctrl_q.baud_div   <= wdata_i[15:0];
        uart_reg_pkg::ADDR_RX_EN:      ctrl_q.rx_en      <= wdata_i[0];
        uart_reg_pkg::ADDR_TX_EN:      ctrl_q.tx_en      <= wdata_i[0];
        uart_reg_pkg::ADDR_RX_TIMEOUT: ctrl_q.rx_timeout <= wdata_i;
        default:                       ctrl_q            <= ctrl_q;
      endcase
    end
  end

  uart_fifo u_tx_fifo (
    .clk_i   ( clk_i              ),
    .rst_ni  ( rst_ni             ),
    .push_i  ( tx_push            ),
    .pop_i   ( tx_start           ),  // pops at the start pulse
    .flush_i ( tx_flush           ),
    .wdata_i ( wdata_i[7:0]       ),
    .rdata_o ( tx_head            ),
    .empty_o ( tx_empty           ),
    .full_o  (                    ),
    .count_o (                    )
  );

  uart_tx u_tx (
    .clk_i      ( clk_i           ),
    .rst_ni     ( rst_ni          ),
    .start_i    ( tx_start        ),
    .data_i     ( tx_head         ),
    .baud_div_i ( ctrl_q.baud_div ),
    .busy_o     ( tx_busy         ),
    .done_o     ( tx_done         ),
    .tx_o       ( tx_o            )
  );

  uart_rx u_rx (
    .clk_i      ( clk_i           ),
    .rst_ni     ( rst_ni          ),
    .rx_i       ( rx_gated        ),
    .baud_div_i ( ctrl_q.baud_div ),
    .start_o    ( rx_start        ),
    .valid_o    ( rx_valid        ),
    .data_o     ( rx_byte         )
  );

  uart_fifo u_rx_fifo (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .push_i  ( rx_valid  ),
    .pop_i   ( rx_pop    ),
    .flush_i ( rx_flush  ),
    .wdata_i ( rx_byte   ),
    .rdata_o ( rx_head   ),
    .empty_o (           ),
    .full_o  (           ),
    .count_o ( rx_count  )
  );

  uart_rx_timer u_rx_timer (
    .clk_i     ( clk_i             ),
    .rst_ni    ( rst_ni            ),
    .en_i      ( ctrl_q.rx_en      ),
    .start_i   ( rx_start          ),
    .limit_i   ( ctrl_q.rx_timeout ),
    .timeout_o ( rx_timeout        )
  );

  // sticky timeout, set wins over clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= 1'b0;
    end else if (rx_timeout) begin
      status_q <= 1'b1;
    end else if (status_clr) begin
      status_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_tx_q <= 1'b0;
    end else begin
      intr_tx_q <= tx_done & tx_empty;  // last queued byte gone
    end
  end

  assign intr_tx_o = intr_tx_q;
  assign intr_rx_o = status_q;

  always_comb begin
    case (addr)
      uart_reg_pkg::ADDR_RX_STATUS: rdata_o = {31'b0, status_q};
      uart_reg_pkg::ADDR_RX_DATA:   rdata_o = 32'(rx_head);
      uart_reg_pkg::ADDR_RX_COUNT:  rdata_o = 32'(rx_count);
      default:                      rdata_o = '0;
    endcase
  end

endmodule

/* uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           push_i,
  input  logic                           pop_i,
  input  logic                           flush_i,
  input  logic [uart_cfg_pkg::DATA_W-1:0] wdata_i,
  output logic [uart_cfg_pkg::DATA_W-1:0] rdata_o,
  output logic                           empty_o,
  output logic                           full_o,
  output logic [uart_cfg_pkg::CNT_W-1:0]  count_o
);

  logic [uart_cfg_pkg::DATA_W-1:0] mem_q [uart_cfg_pkg::FIFO_DEPTH];
  logic [uart_cfg_pkg::CNT_W-2:0]  wr_ptr_q;  // wraps at the depth
  logic [uart_cfg_pkg::CNT_W-2:0]  rd_ptr_q;
  logic [uart_cfg_pkg::CNT_W-1:0]  count_q;
  logic                            do_push;
  logic                            do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == uart_cfg_pkg::CNT_W'(uart_cfg_pkg::FIFO_DEPTH));
  assign count_o = count_q;
  assign rdata_o = mem_q[rd_ptr_q];  // first word falls through

  assign do_push = push_i & ~full_o;   // dropped when full
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

endmodule

/* uart_reg_pkg.sv */
package uart_reg_pkg;

  // byte offsets on the register bus
  typedef enum logic [7:0] {
    ADDR_CTRL          = 8'd0,   // baud divisor, write
    ADDR_TX_DATA       = 8'd4,   // push to tx fifo
    ADDR_RX_DATA       = 8'd8,   // rx fifo head, pop on read
    ADDR_RX_EN         = 8'd12,
    ADDR_TX_EN         = 8'd16,
    ADDR_RX_STATUS     = 8'd20,  // timeout flag in bit 0
    ADDR_RX_STATUS_CLR = 8'd24,
    ADDR_TX_FLUSH      = 8'd28,
    ADDR_RX_TIMEOUT    = 8'd40,  // idle clocks before timeout
    ADDR_RX_FLUSH      = 8'd44,
    ADDR_RX_COUNT      = 8'd52   // rx fifo occupancy
  } reg_addr_e;

  typedef struct packed {
    uart_cfg_pkg::baud_div_t baud_div;
    logic                    rx_en;
    logic                    tx_en;
    logic [31:0]             rx_timeout;  // 0 disables the timer
  } uart_ctrl_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            rx_i,
  input  uart_cfg_pkg::baud_div_t         baud_div_i,
  output logic                            start_o,
  output logic                            valid_o,
  output logic [uart_cfg_pkg::DATA_W-1:0] data_o
);

  uart_cfg_pkg::rx_state_e         state_q;
  uart_cfg_pkg::baud_div_t         clk_cnt_q;
  uart_cfg_pkg::baud_div_t         half_div;
  logic [2:0]                      bit_idx_q;
  logic [uart_cfg_pkg::DATA_W-1:0] shift_q;
  logic                            rx_meta_q;
  logic                            rx_sync_q;
  logic                            start_q;
  logic                            valid_q;
  logic                            bit_end;
  logic                            half_end;

  assign half_div = baud_div_i >> 1;
  assign bit_end  = (clk_cnt_q == baud_div_i - 16'd1);
  assign half_end = (clk_cnt_q == half_div - 16'd1);
  assign start_o  = start_q;
  assign valid_o  = valid_q;
  assign data_o   = shift_q;

  // two-flop synchronizer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= uart_cfg_pkg::RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      start_q   <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      start_q   <= 1'b0;
      valid_q   <= 1'b0;
      clk_cnt_q <= clk_cnt_q + 16'd1;
      case (state_q)
        uart_cfg_pkg::RX_IDLE: begin
          clk_cnt_q <= '0;
          if (!rx_sync_q) begin
            state_q <= uart_cfg_pkg::RX_START;
          end
        end
        uart_cfg_pkg::RX_START: begin
          if (half_end) begin
            clk_cnt_q <= '0;
            if (!rx_sync_q) begin  // still low at mid start bit
              start_q   <= 1'b1;
              bit_idx_q <= '0;
              state_q   <= uart_cfg_pkg::RX_DATA;
            end else begin
              state_q <= uart_cfg_pkg::RX_IDLE;  // glitch
            end
          end
        end
        uart_cfg_pkg::RX_DATA: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'(uart_cfg_pkg::DATA_W - 1)) begin
              state_q <= uart_cfg_pkg::RX_STOP;
            end
          end
        end
        uart_cfg_pkg::RX_STOP: begin
          if (bit_end) begin
            valid_q <= 1'b1;  // stop bit level not checked
            state_q <= uart_cfg_pkg::RX_IDLE;
          end
        end
        default: state_q <= uart_cfg_pkg::RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == uart_cfg_pkg::RX_DATA && bit_end) begin
      shift_q <= {rx_sync_q, shift_q[uart_cfg_pkg::DATA_W-1:1]};  // lsb first
    end
  end

endmodule

/* uart_rx_timer.sv */
`timescale 1ns/1ps

module uart_rx_timer (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        en_i,
  input  logic        start_i,
  input  logic [31:0] limit_i,
  output logic        timeout_o
);

  logic [31:0] cnt_q;
  logic        run;

  // counts only while enabled and below the limit
  assign run = en_i && !start_i && (limit_i != '0) && (cnt_q < limit_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      timeout_o <= 1'b0;
    end else begin
      timeout_o <= 1'b0;
      if (!en_i || start_i) begin
        cnt_q <= '0;  // new frame or receiver off
      end else if (run) begin
        cnt_q <= cnt_q + 32'd1;
        if (cnt_q == limit_i - 32'd1) begin
          timeout_o <= 1'b1;  // once, counter parks at limit
        end
      end
    end
  end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  logic [uart_cfg_pkg::DATA_W-1:0] data_i,
  input  uart_cfg_pkg::baud_div_t         baud_div_i,
  output logic                            busy_o,
  output logic                            done_o,
  output logic                            tx_o
);

  uart_cfg_pkg::tx_state_e         state_q;
  uart_cfg_pkg::baud_div_t         clk_cnt_q;
  logic [2:0]                      bit_idx_q;
  logic [uart_cfg_pkg::DATA_W-1:0] shift_q;
  logic                            tx_q;
  logic                            done_q;
  logic                            bit_end;

  assign bit_end = (clk_cnt_q == baud_div_i - 16'd1);
  assign busy_o  = (state_q != uart_cfg_pkg::TX_IDLE);
  assign done_o  = done_q;
  assign tx_o    = tx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= uart_cfg_pkg::TX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      tx_q      <= 1'b1;  // line idles high
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state_q != uart_cfg_pkg::TX_IDLE) begin
        clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 16'd1;
      end
      case (state_q)
        uart_cfg_pkg::TX_IDLE: begin
          if (start_i) begin
            tx_q      <= 1'b0;  // start bit
            clk_cnt_q <= '0;
            state_q   <= uart_cfg_pkg::TX_START;
          end
        end
        uart_cfg_pkg::TX_START: begin
          if (bit_end) begin
            tx_q      <= shift_q[0];
            bit_idx_q <= '0;
            state_q   <= uart_cfg_pkg::TX_DATA;
          end
        end
        uart_cfg_pkg::TX_DATA: begin
          if (bit_end) begin
            if (bit_idx_q == 3'(uart_cfg_pkg::DATA_W - 1)) begin
              tx_q    <= 1'b1;  // stop bit
              state_q <= uart_cfg_pkg::TX_STOP;
            end else begin
              tx_q      <= shift_q[1];
              bit_idx_q <= bit_idx_q + 3'd1;
            end
          end
        end
        uart_cfg_pkg::TX_STOP: begin
          if (bit_end) begin
            done_q  <= 1'b1;
            state_q <= uart_cfg_pkg::TX_IDLE;
          end
        end
        default: state_q <= uart_cfg_pkg::TX_IDLE;
      endcase
    end
  end

  // payload shift register, lsb first
  always_ff @(posedge clk_i) begin
    if (state_q == uart_cfg_pkg::TX_IDLE && start_i) begin
      shift_q <= data_i;
    end else if (state_q == uart_cfg_pkg::TX_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule
